//--- verilog/nn_pkg.sv
package nn_pkg;

	////////////////////////////////////////
	// Network shape
	////////////////////////////////////////

	// Neurons per layer, same as inputs per layer
	localparam int NUM_NEURONS = 7;
	localparam int NUM_LAYERS = 3;

	////////////////////////////////////////
	// Fixed point, Q4.4 in 9 bits
	////////////////////////////////////////

	localparam int DATA_WIDTH = 9;
	localparam int FRAC_BITS = 4;
	// Seven 18-bit products plus the scaled bias
	localparam int ACC_WIDTH = 22;

	// Layer and step indices, step 7 is the bias step
	localparam int LAYER_BITS = 2;
	localparam int STEP_BITS = 3;

	////////////////////////////////////////
	// Derived sizes
	////////////////////////////////////////

	// Eight steps per layer plus the final write-back
	localparam int NN_LATENCY = NUM_LAYERS * (NUM_NEURONS + 1) + 1;
	// One ROM line per neuron per layer
	localparam int ROM_DEPTH = NUM_LAYERS * NUM_NEURONS;

endpackage

//--- verilog/layer_sequencer.sv
`timescale 1ns/1ps

module layer_sequencer (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic [nn_pkg::LAYER_BITS-1:0] layer,
	output logic [nn_pkg::STEP_BITS-1:0] step,
	output logic load,
	output logic clear,
	output logic accumulate,
	output logic write_back,
	output logic relu_en,
	output logic done,
	output logic busy
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_FLUSH
	} state_t;

	state_t state;
	logic last_layer;

	// Output layer gets no ReLU and no follow-on layer
	assign last_layer = int'(layer) == nn_pkg::NUM_LAYERS - 1;

	////////////////////////////////////////
	// State and counters
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			layer <= '0;
			step <= '0;
			write_back <= 1'b0;
			relu_en <= 1'b0;
		end else begin
			// Write-back lands in the cycle after each bias step
			write_back <= (state == S_RUN) && (&step);
			// ReLU flag tracks the layer being written back
			relu_en <= !last_layer;
			case (state)
				S_IDLE: begin
					// New inference, start ignored otherwise
					if (start) begin
						state <= S_RUN;
						layer <= '0;
						step <= '0;
					end
				end
				S_RUN: begin
					// Step wraps 7 -> 0 on its own
					step <= step + 1'b1;
					if (&step) begin
						if (last_layer) begin
							state <= S_FLUSH;
						end else begin
							// Next layer starts during this write-back
							layer <= layer + 1'b1;
						end
					end
				end
				S_FLUSH: begin
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Strobes
	////////////////////////////////////////

	assign busy = state != S_IDLE;
	// Inputs captured on the same edge that accepts start
	assign load = start && (state == S_IDLE);
	assign accumulate = state == S_RUN;
	// Fresh sum on the first input of each layer
	assign clear = accumulate && (step == '0);
	// Final write-back cycle
	assign done = state == S_FLUSH;

endmodule

//--- verilog/weight_rom.sv
`timescale 1ns/1ps

module weight_rom (
	input  logic [nn_pkg::LAYER_BITS-1:0] layer,
	input  logic [nn_pkg::STEP_BITS-1:0] step,
	output logic signed [nn_pkg::DATA_WIDTH-1:0] weights [nn_pkg::NUM_NEURONS]
);

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	// Line per neuron, eight words per line
	// Words 0..6 are input weights, word 7 the bias
	logic signed [nn_pkg::DATA_WIDTH-1:0] rom [nn_pkg::ROM_DEPTH * (2 ** nn_pkg::STEP_BITS)];

	initial begin
		$readmemh("verilog/weights.mem", rom);
	end

	////////////////////////////////////////
	// Read port
	////////////////////////////////////////

	// All seven neurons of the layer read in parallel
	always_comb begin
		logic [$clog2(nn_pkg::ROM_DEPTH)-1:0] line;
		for (int i = 0; i < nn_pkg::NUM_NEURONS; i++) begin
			// Lines grouped by layer, then neuron
			line = $clog2(nn_pkg::ROM_DEPTH)'(int'(layer) * nn_pkg::NUM_NEURONS + i);
			// Word address is line and step side by side
			weights[i] = rom[{line, step}];
		end
	end

endmodule

//--- verilog/activation_buffer.sv
`timescale 1ns/1ps

module activation_buffer (
	input  logic clk,
	input  logic rst_n,
	input  logic load,
	input  logic write_back,
	input  logic relu_en,
	input  logic [nn_pkg::NUM_NEURONS*nn_pkg::DATA_WIDTH-1:0] start_input,
	input  logic signed [nn_pkg::DATA_WIDTH-1:0] results [nn_pkg::NUM_NEURONS],
	input  logic [nn_pkg::STEP_BITS-1:0] step,
	output logic signed [nn_pkg::DATA_WIDTH-1:0] activation,
	output logic [nn_pkg::NUM_NEURONS*nn_pkg::DATA_WIDTH-1:0] state_flat
);

	logic signed [nn_pkg::DATA_WIDTH-1:0] act_q [nn_pkg::NUM_NEURONS];
	logic signed [nn_pkg::DATA_WIDTH-1:0] act_view [nn_pkg::NUM_NEURONS];

	////////////////////////////////////////
	// Incoming values
	////////////////////////////////////////

	// Write-through view, so step 0 of the next layer
	// already sees the results being written back
	always_comb begin
		for (int i = 0; i < nn_pkg::NUM_NEURONS; i++) begin
			if (!write_back) begin
				act_view[i] = act_q[i];
			end else if (relu_en && results[i][nn_pkg::DATA_WIDTH-1]) begin
				// ReLU, negatives to zero
				act_view[i] = '0;
			end else begin
				act_view[i] = results[i];
			end
		end
	end

	////////////////////////////////////////
	// Activation registers
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < nn_pkg::NUM_NEURONS; i++) begin
				act_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < nn_pkg::NUM_NEURONS; i++) begin
				// Lane i sits at bits i*9 upward
				if (load) begin
					act_q[i] <= start_input[i*nn_pkg::DATA_WIDTH +: nn_pkg::DATA_WIDTH];
				end else if (write_back) begin
					act_q[i] <= act_view[i];
				end
			end
		end
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////

	// Bias step multiplies by 1.0 in Q4.4
	always_comb begin
		activation = '0;
		if (&step) begin
			activation[nn_pkg::FRAC_BITS] = 1'b1;
		end else begin
			for (int i = 0; i < nn_pkg::NUM_NEURONS; i++) begin
				if (int'(step) == i) begin
					activation = act_view[i];
				end
			end
		end
	end

	// Packed like start_input
	always_comb begin
		for (int i = 0; i < nn_pkg::NUM_NEURONS; i++) begin
			state_flat[i*nn_pkg::DATA_WIDTH +: nn_pkg::DATA_WIDTH] = act_view[i];
		end
	end

endmodule

//--- verilog/neuron_array.sv
`timescale 1ns/1ps

module neuron_array (
	input  logic clk,
	input  logic rst_n,
	input  logic clear,
	input  logic accumulate,
	input  logic signed [nn_pkg::DATA_WIDTH-1:0] activation,
	input  logic signed [nn_pkg::DATA_WIDTH-1:0] weights [nn_pkg::NUM_NEURONS],
	output logic signed [nn_pkg::DATA_WIDTH-1:0] results [nn_pkg::NUM_NEURONS]
);

	genvar i;

	generate
		for (i = 0; i < nn_pkg::NUM_NEURONS; i++) begin : g_lane
			// Q4.4 times Q4.4 gives Q8.8 in 18 bits
			logic signed [2*nn_pkg::DATA_WIDTH-1:0] prod;
			logic signed [nn_pkg::ACC_WIDTH-1:0] prod_ext;
			logic signed [nn_pkg::ACC_WIDTH-1:0] sum;
			logic signed [nn_pkg::ACC_WIDTH-1:0] acc_q;
			logic signed [nn_pkg::ACC_WIDTH-1:0] shifted;
			// Bits that must all match the sign to fit 9 bits
			logic [nn_pkg::ACC_WIDTH-nn_pkg::DATA_WIDTH:0] upper;

			////////////////////////////////////////
			// Multiply-accumulate
			////////////////////////////////////////

			assign prod = weights[i] * activation;
			// Sign extension to accumulator width
			assign prod_ext = {
				{(nn_pkg::ACC_WIDTH - 2*nn_pkg::DATA_WIDTH){prod[2*nn_pkg::DATA_WIDTH-1]}},
				prod
			};
			// Clear starts the layer with the first product
			assign sum = clear ? prod_ext : acc_q + prod_ext;

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					acc_q <= '0;
				end else if (accumulate) begin
					acc_q <= sum;
				end
			end

			////////////////////////////////////////
			// Rescale and saturate
			////////////////////////////////////////

			// Q8.8 back to Q4.4
			assign shifted = acc_q >>> nn_pkg::FRAC_BITS;
			assign upper = shifted[nn_pkg::ACC_WIDTH-1:nn_pkg::DATA_WIDTH-1];

			always_comb begin
				if ((&upper) || !(|upper)) begin
					// In range, plain truncation
					results[i] = shifted[nn_pkg::DATA_WIDTH-1:0];
				end else if (shifted[nn_pkg::ACC_WIDTH-1]) begin
					// Clip to -256
					results[i] = {1'b1, {(nn_pkg::DATA_WIDTH-1){1'b0}}};
				end else begin
					// Clip to 255
					results[i] = {1'b0, {(nn_pkg::DATA_WIDTH-1){1'b1}}};
				end
			end
		end
	endgenerate

endmodule

//--- verilog/layer_mux_nn.sv
`timescale 1ns/1ps

module layer_mux_nn (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic [nn_pkg::NUM_NEURONS*nn_pkg::DATA_WIDTH-1:0] start_input,
	output logic [nn_pkg::NUM_NEURONS*nn_pkg::DATA_WIDTH-1:0] final_output,
	output logic final_output_valid
);

	logic [nn_pkg::LAYER_BITS-1:0] layer;
	logic [nn_pkg::STEP_BITS-1:0] step;
	logic load;
	logic clear;
	logic accumulate;
	logic write_back;
	logic relu_en;
	logic done;
	logic signed [nn_pkg::DATA_WIDTH-1:0] weights [nn_pkg::NUM_NEURONS];
	logic signed [nn_pkg::DATA_WIDTH-1:0] results [nn_pkg::NUM_NEURONS];
	logic signed [nn_pkg::DATA_WIDTH-1:0] activation;
	logic [nn_pkg::NUM_NEURONS*nn_pkg::DATA_WIDTH-1:0] state_flat;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	layer_sequencer layer_sequencer_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.layer      (layer),
		.step       (step),
		.load       (load),
		.clear      (clear),
		.accumulate (accumulate),
		.write_back (write_back),
		.relu_en    (relu_en),
		.done       (done),
		.busy       ()
	);

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	// Weights and activation both selected by step
	weight_rom weight_rom_inst (
		.layer   (layer),
		.step    (step),
		.weights (weights)
	);

	activation_buffer activation_buffer_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.load        (load),
		.write_back  (write_back),
		.relu_en     (relu_en),
		.start_input (start_input),
		.results     (results),
		.step        (step),
		.activation  (activation),
		.state_flat  (state_flat)
	);

	neuron_array neuron_array_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.clear      (clear),
		.accumulate (accumulate),
		.activation (activation),
		.weights    (weights),
		.results    (results)
	);

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	// One pulse per finished inference
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			final_output_valid <= 1'b0;
		end else begin
			final_output_valid <= done;
		end
	end

	// Held until the next result
	always_ff @(posedge clk) begin
		if (done) begin
			final_output <= state_flat;
		end
	end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 20
) (
	output logic clk
);

	// Free-running, starts low
	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

endmodule

//--- verification/tb_layer_mux_nn.sv
`timescale 1ns/1ps

module tb_layer_mux_nn;

	localparam int NN = nn_pkg::NUM_NEURONS;
	localparam int DW = nn_pkg::DATA_WIDTH;
	localparam int VW = NN * DW;
	// Model side, bias is word 7 of each ROM line
	localparam int LAYERS = 3;
	localparam int LINE_WORDS = 8;
	// 1.0 in Q4.4
	localparam int ONE = 16;
	// Inferences over all tests
	localparam int RUNS = 28;
	localparam int TIMEOUT_NS = (RUNS + 4) * (nn_pkg::NN_LATENCY + 10) * 20;

	logic clk;
	logic rst_n;
	logic start;
	logic [VW-1:0] start_input;
	logic [VW-1:0] final_output;
	logic final_output_valid;
	logic [DW-1:0] ref_rom [LAYERS * NN * LINE_WORDS];

	tb_clock_gen #(.PERIOD_NS(20)) tb_clock_gen_inst (.clk(clk));

	layer_mux_nn layer_mux_nn_inst (
		.clk                (clk),
		.rst_n              (rst_n),
		.start              (start),
		.start_input        (start_input),
		.final_output       (final_output),
		.final_output_valid (final_output_valid)
	);

	////////////////////////////////////////
	// Failure and compare
	////////////////////////////////////////

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("error %s: got 0x%h, expected 0x%h",
				name, actual, expected));
		end
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic int to_int(input logic [DW-1:0] v);
		return v[DW-1] ? int'(v) - (1 << DW) : int'(v);
	endfunction

	// Lane 0 in the low bits
	function automatic logic [VW-1:0] pack_lanes(input int a0, a1, a2, a3, a4, a5, a6);
		return {a6[DW-1:0], a5[DW-1:0], a4[DW-1:0], a3[DW-1:0],
			a2[DW-1:0], a1[DW-1:0], a0[DW-1:0]};
	endfunction

	function automatic logic [VW-1:0] expected_output(input logic [VW-1:0] vec);
		int act [NN];
		int nxt [NN];
		int acc;
		int base;
		logic [VW-1:0] result;
		for (int k = 0; k < NN; k++) begin
			act[k] = to_int(vec[k*DW +: DW]);
		end
		for (int l = 0; l < LAYERS; l++) begin
			for (int n = 0; n < NN; n++) begin
				base = (l * NN + n) * LINE_WORDS;
				// Bias enters scaled by 1.0
				acc = to_int(ref_rom[base + NN]) * ONE;
				for (int k = 0; k < NN; k++) begin
					acc += to_int(ref_rom[base + k]) * act[k];
				end
				// Q8.8 down to Q4.4, then clip to 9 bits
				acc = acc >>> 4;
				if (acc > 255) begin
					acc = 255;
				end else if (acc < -256) begin
					acc = -256;
				end
				// ReLU on hidden layers only
				if (l < LAYERS - 1 && acc < 0) begin
					acc = 0;
				end
				nxt[n] = acc;
			end
			act = nxt;
		end
		for (int k = 0; k < NN; k++) begin
			result[k*DW +: DW] = act[k][DW-1:0];
		end
		return result;
	endfunction

	////////////////////////////////////////
	// Drive and wait
	////////////////////////////////////////

	// Optional second start, sampled second_at cycles after the first
	task automatic run_and_check(input logic [VW-1:0] vec, input int second_at,
			input logic [VW-1:0] second_vec);
		int cycles;
		logic [VW-1:0] held;
		held = final_output;
		start_input = vec;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		cycles = 0;
		while (!final_output_valid) begin
			if (cycles > 4 * nn_pkg::NN_LATENCY) begin
				stop_with_failure("no valid pulse arrived after start");
			end
			// Previous result stays put while the engine runs
			check("final_output", final_output, held);
			@(negedge clk);
			cycles++;
			start = (cycles + 1 == second_at);
			if (start) begin
				start_input = second_vec;
			end
		end
		start = 1'b0;
		check("final_output_valid latency", cycles, nn_pkg::NN_LATENCY);
		check("final_output", final_output, expected_output(vec));
		// Pulse is one cycle wide
		@(negedge clk);
		check("final_output_valid", final_output_valid, 1'b0);
	endtask

	task automatic check_idle(input int cycles, input logic [VW-1:0] held);
		repeat (cycles) begin
			@(negedge clk);
			check("final_output_valid", final_output_valid, 1'b0);
			check("final_output", final_output, held);
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_reset_quiet();
		repeat (10) begin
			@(negedge clk);
			check("final_output_valid", final_output_valid, 1'b0);
		end
	endtask

	task automatic test_reference_vectors();
		run_and_check(pack_lanes(16, 8, -4, 32, 0, -16, 12), -1, '0);
		run_and_check(pack_lanes(4, 4, 4, 4, 4, 4, 4), -1, '0);
		run_and_check(pack_lanes(-32, 40, 2, -8, 24, 6, -20), -1, '0);
	endtask

	// Full-scale inputs push lanes into clipping
	task automatic test_saturation();
		run_and_check(pack_lanes(255, 255, 255, 255, 255, 255, 255), -1, '0);
		run_and_check(pack_lanes(-256, -256, -256, -256, -256, -256, -256), -1, '0);
	endtask

	task automatic test_busy_start_ignored();
		run_and_check(pack_lanes(20, -12, 8, 0, 36, -4, 10), 5,
			pack_lanes(-100, 90, -80, 70, -60, 50, -40));
		check_idle(30, final_output);
	endtask

	task automatic test_random_back_to_back();
		logic [VW-1:0] vec;
		repeat (20) begin
			for (int k = 0; k < NN; k++) begin
				vec[k*DW +: DW] = DW'($urandom);
			end
			run_and_check(vec, -1, '0);
		end
	endtask

	task automatic test_output_hold();
		run_and_check(pack_lanes(2, 30, -6, 14, -22, 8, 0), -1, '0);
		check_idle(40, final_output);
		run_and_check(pack_lanes(-10, 0, 18, -2, 6, 26, -14), -1, '0);
		check_idle(20, final_output);
	endtask

	////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		start_input = '0;
		void'($urandom(98));
		$readmemh("verilog/weights.mem", ref_rom);
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		test_reset_quiet();
		test_reference_vectors();
		test_saturation();
		test_busy_start_ignored();
		test_random_back_to_back();
		test_output_hold();
		$display("TEST PASSED");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		stop_with_failure("the run timed out before all tests finished");
	end

endmodule

//--- layer_mux_nn.f
verilog/nn_pkg.sv
verilog/layer_sequencer.sv
verilog/weight_rom.sv
verilog/activation_buffer.sv
verilog/neuron_array.sv
verilog/layer_mux_nn.sv
verification/tb_clock_gen.sv
verification/tb_layer_mux_nn.sv

//--- Makefile
# Verilator simulation of the layer-multiplexed NN engine
TOP = tb_layer_mux_nn

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build folder"
	@echo "make help   show this list"

# Pass only when the simulation output holds the pass line
test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f layer_mux_nn.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- verilog/weights.mem
// Per line: seven weights then the bias, Q4.4 hex, 9-bit two's complement
// Lines 0-6 layer 0, lines 7-13 layer 1, lines 14-20 layer 2
008 008 008 008 008 008 008 004
1FC 006 00A 1F8 004 002 1FE 008
00C 1F4 004 002 1F8 00A 006 1FC
002 004 1FA 00C 006 1FC 008 010
1F8 1FE 004 006 00A 008 1FC 000
006 00A 1FE 1FC 002 00C 1F8 1F8
010 1F0 008 004 1FC 002 006 00C
004 1FA 00C 002 1FE 008 006 1FC
00A 004 1F8 006 00C 1FE 002 006
1FE 008 006 1F4 004 00A 1FC 002
006 00C 002 004 1F8 1FA 00A 1F0
1FC 002 00A 008 006 004 1F4 008
008 1F8 004 00A 002 006 00C 1FE
002 006 1FC 1FE 00A 00C 004 004
00C 1FC 006 002 008 1FA 004 1F8
1FA 00A 004 00C 1FE 002 008 00A
004 002 1F4 006 00A 008 1FE 000
008 006 00A 1F8 004 1FC 00C 1FC
1FE 00C 002 004 1F6 00A 006 006
006 1FC 008 00A 00C 1F8 002 1FA
00A 004 006 1FE 002 004 1F0 00C
